//--- hw/apm_config.svh
////////////////////////////////////////
// AXI performance monitor configuration
// Counter widths, register map offsets
// and the capability word
////////////////////////////////////////

`ifndef APM_CONFIG_SVH
`define APM_CONFIG_SVH

// Counter widths
`define APM_CW_CLK       32
`define APM_CW_HS        16
`define APM_CW_FL_MAX    8
`define APM_CW_FL_ACC    24
`define APM_CW_STALL     16
`define APM_CW_STALL_MAX 4
`define APM_CW_EXCL      8

`define APM_N_STATS      22

// Register map
`define APM_ADDR_CAP     12'h000
`define APM_ADDR_CTRL    12'h004
`define APM_ADDR_STAT    12'h008

// Clock, handshakes, in flight, stalls, exclusives
`define APM_CAP_VALUE    32'h0000_00A7

`endif

//--- hw/apm_pkg.sv
////////////////////////////////////////
// AXI performance monitor types
// Channel handshake structs, statistic
// words and the control register
////////////////////////////////////////

`default_nettype none

`include "apm_config.svh"

package apm_pkg;

  typedef logic [11:0] apb_addr_t;
  typedef logic [31:0] apb_data_t;
  typedef logic [1:0]  resp_t;

  typedef struct packed {
    logic valid;
    logic ready;
  } chan_hs_t;

  // AR and AW
  typedef struct packed {
    chan_hs_t hs;
    logic     lock;
  } cmd_chan_t;

  typedef struct packed {
    chan_hs_t hs;
    logic     last;
  } r_chan_t;

  typedef struct packed {
    chan_hs_t hs;
    resp_t    resp;
  } b_chan_t;

  // One readout statistic, value zero-extended to 32 bits
  typedef struct packed {
    logic      oflw;
    apb_data_t value;
  } stat_t;

  typedef stat_t [`APM_N_STATS-1:0] stat_bank_t;

  typedef struct packed {
    logic clr;
    logic en;
  } ctrl_t;

endpackage

`default_nettype wire

//--- hw/apm_event_counter.sv
////////////////////////////////////////
// Event counter
// Clearable up-counter with a sticky
// overflow flag
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module apm_event_counter #(
  parameter int unsigned WIDTH = 16
) (
  input  logic           clk_axi_i,
  input  logic           rst_n_i,
  input  logic           clr_i,
  input  logic           inc_i,
  output apm_pkg::stat_t stat_o
);

  logic [WIDTH-1:0] cnt_q;
  logic             oflw_q;
  logic [WIDTH:0]   cnt_inc;

  // Top bit is the carry out
  assign cnt_inc = {1'b0, cnt_q} + 1'b1;

  always_ff @(posedge clk_axi_i) begin
    if (!rst_n_i || clr_i) begin
      cnt_q  <= '0;
      oflw_q <= 1'b0;
    end else if (inc_i) begin
      cnt_q  <= cnt_inc[WIDTH-1:0];
      oflw_q <= oflw_q | cnt_inc[WIDTH];
    end
  end

  always_comb begin
    stat_o                  = '0;
    stat_o.oflw             = oflw_q;
    stat_o.value[WIDTH-1:0] = cnt_q;
  end

endmodule

`default_nettype wire

//--- hw/apm_stall_tracker.sv
////////////////////////////////////////
// Stall tracker
// Counts valid-without-ready cycles of
// one channel and the longest stall run
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "apm_config.svh"

module apm_stall_tracker (
  input  logic              clk_axi_i,
  input  logic              rst_n_i,
  input  apm_pkg::ctrl_t    ctrl_i,
  input  apm_pkg::chan_hs_t chan_i,
  output apm_pkg::stat_t    total_o,
  output apm_pkg::stat_t    max_o
);

  localparam int unsigned MW = `APM_CW_STALL_MAX;

  logic          stall;
  logic          hs;
  logic          run_sat;
  logic [MW-1:0] run_q;
  logic [MW-1:0] run_d;
  logic [MW-1:0] max_q;
  logic          max_oflw_q;

  assign stall = chan_i.valid & ~chan_i.ready;
  assign hs    = chan_i.valid & chan_i.ready;

  apm_event_counter #(
    .WIDTH (`APM_CW_STALL)
  ) i_total (
    .clk_axi_i (clk_axi_i),
    .rst_n_i   (rst_n_i),
    .clr_i     (ctrl_i.clr),
    .inc_i     (ctrl_i.en & stall),
    .stat_o    (total_o)
  );

  // A stall cycle with the run already at all ones overflows the maximum
  assign run_sat = ctrl_i.en & stall & (run_q == '1);

  always_comb begin
    run_d = run_q;
    if (hs) begin
      run_d = '0;
    end else if (ctrl_i.en && stall && !run_sat) begin
      run_d = run_q + 1'b1;
    end
  end

  always_ff @(posedge clk_axi_i) begin
    if (!rst_n_i || ctrl_i.clr) begin
      run_q      <= '0;
      max_q      <= '0;
      max_oflw_q <= 1'b0;
    end else begin
      run_q <= run_d;
      if (run_d > max_q) begin
        max_q <= run_d;
      end
      if (run_sat) begin
        max_oflw_q <= 1'b1;
      end
    end
  end

  always_comb begin
    max_o               = '0;
    max_o.oflw          = max_oflw_q;
    max_o.value[MW-1:0] = max_q;
  end

endmodule

`default_nettype wire

//--- hw/apm_inflight_tracker.sv
////////////////////////////////////////
// In-flight tracker
// Up/down count of open transactions,
// its maximum and per-cycle sum
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "apm_config.svh"

module apm_inflight_tracker (
  input  logic           clk_axi_i,
  input  logic           rst_n_i,
  input  apm_pkg::ctrl_t ctrl_i,
  input  logic           inc_i,
  input  logic           dec_i,
  output apm_pkg::stat_t acc_o,
  output apm_pkg::stat_t max_o
);

  localparam int unsigned CW = `APM_CW_FL_MAX;
  localparam int unsigned AW = `APM_CW_FL_ACC;

  logic          up;
  logic          down;
  logic [CW:0]   cnt_d;
  logic [CW-1:0] cnt_q;
  logic [CW-1:0] max_q;
  logic          cnt_oflw_q;
  logic [AW:0]   acc_sum;
  logic [AW-1:0] acc_q;
  logic          acc_oflw_q;

  // Simultaneous open and close cancel
  assign up   = ctrl_i.en & inc_i & ~dec_i;
  assign down = ctrl_i.en & dec_i & ~inc_i;

  // MSB flags a wrap in either direction
  always_comb begin
    cnt_d = {1'b0, cnt_q};
    if (up) begin
      cnt_d = {1'b0, cnt_q} + 1'b1;
    end else if (down) begin
      cnt_d = {1'b0, cnt_q} - 1'b1;
    end
  end

  assign acc_sum = {1'b0, acc_q} + {{(AW - CW + 1){1'b0}}, cnt_q};

  always_ff @(posedge clk_axi_i) begin
    if (!rst_n_i || ctrl_i.clr) begin
      cnt_q      <= '0;
      max_q      <= '0;
      cnt_oflw_q <= 1'b0;
      acc_q      <= '0;
      acc_oflw_q <= 1'b0;
    end else begin
      cnt_q <= cnt_d[CW-1:0];
      if (cnt_d[CW]) begin
        cnt_oflw_q <= 1'b1;
      end
      if (cnt_d[CW-1:0] > max_q) begin
        max_q <= cnt_d[CW-1:0];
      end
      if (ctrl_i.en) begin
        acc_q <= acc_sum[AW-1:0];
        if (acc_sum[AW]) begin
          acc_oflw_q <= 1'b1;
        end
      end
    end
  end

  always_comb begin
    acc_o               = '0;
    acc_o.oflw          = acc_oflw_q | cnt_oflw_q;
    acc_o.value[AW-1:0] = acc_q;
    max_o               = '0;
    max_o.oflw          = cnt_oflw_q;
    max_o.value[CW-1:0] = max_q;
  end

endmodule

`default_nettype wire

//--- hw/apm_regs.sv
////////////////////////////////////////
// Monitor register file
// APB slave with capability, control
// and statistic readout words
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "apm_config.svh"

module apm_regs (
  input  logic                clk_axi_i,
  input  logic                rst_n_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  apm_pkg::apb_addr_t  paddr_i,
  input  apm_pkg::apb_data_t  pwdata_i,
  input  apm_pkg::stat_bank_t stats_i,
  output apm_pkg::apb_data_t  prdata_o,
  output logic                pslverr_o,
  output apm_pkg::ctrl_t      ctrl_o
);

  import apm_pkg::*;

  logic      access;
  logic      ctrl_we;
  logic      stat_hit;
  logic      rd_err;
  apb_addr_t stat_off;
  logic [8:0] stat_idx;
  apb_data_t rdata;
  ctrl_t     ctrl_q;

  assign access = psel_i & penable_i;

  // Two words per statistic, value then overflow
  assign stat_off = paddr_i - `APM_ADDR_STAT;
  assign stat_idx = stat_off[11:3];
  assign stat_hit = (paddr_i >= `APM_ADDR_STAT) && (stat_idx < `APM_N_STATS) &&
                    (paddr_i[1:0] == 2'b00);

  always_comb begin
    rdata  = '0;
    rd_err = 1'b0;
    if (paddr_i == `APM_ADDR_CAP) begin
      rdata = `APM_CAP_VALUE;
    end else if (paddr_i == `APM_ADDR_CTRL) begin
      rdata = {30'b0, ctrl_q};
    end else if (stat_hit) begin
      if (stat_off[2]) begin
        rdata = {stats_i[stat_idx].oflw, 31'b0};
      end else begin
        rdata = stats_i[stat_idx].value;
      end
    end else begin
      rd_err = 1'b1;
    end
  end

  assign prdata_o  = (access && !pwrite_i) ? rdata : '0;

  // Only the control word is writable
  assign pslverr_o = access && (pwrite_i ? (paddr_i != `APM_ADDR_CTRL) : rd_err);

  assign ctrl_we = access & pwrite_i & (paddr_i == `APM_ADDR_CTRL);

  always_ff @(posedge clk_axi_i) begin
    if (!rst_n_i) begin
      ctrl_q <= '0;
    end else if (ctrl_we) begin
      ctrl_q <= ctrl_t'(pwdata_i[1:0]);
    end
  end

  assign ctrl_o = ctrl_q;

endmodule

`default_nettype wire

//--- hw/axi_perf_mon.sv
////////////////////////////////////////
// AXI performance monitor
// Observes one AXI port and exposes
// traffic statistics over APB
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "apm_config.svh"

module axi_perf_mon (
  input  logic               clk_axi_i,
  input  logic               rst_n_i,
  // Monitored AXI channels
  input  apm_pkg::cmd_chan_t ar_i,
  input  apm_pkg::cmd_chan_t aw_i,
  input  apm_pkg::r_chan_t   r_i,
  input  apm_pkg::chan_hs_t  w_i,
  input  apm_pkg::b_chan_t   b_i,
  // APB readout and control
  input  logic               psel_i,
  input  logic               penable_i,
  input  logic               pwrite_i,
  input  apm_pkg::apb_addr_t paddr_i,
  input  apm_pkg::apb_data_t pwdata_i,
  output apm_pkg::apb_data_t prdata_o,
  output logic               pslverr_o
);

  import apm_pkg::*;

  ctrl_t          ctrl;
  stat_bank_t     stats;
  logic           ar_hs;
  logic           aw_hs;
  logic           r_hs;
  logic           w_hs;
  logic           b_hs;
  logic [3:0]     hs_evt;
  logic [2:0]     excl_evt;
  chan_hs_t [4:0] stall_chan;

  assign ar_hs = ar_i.hs.valid & ar_i.hs.ready;
  assign aw_hs = aw_i.hs.valid & aw_i.hs.ready;
  assign r_hs  = r_i.hs.valid & r_i.hs.ready;
  assign w_hs  = w_i.valid & w_i.ready;
  assign b_hs  = b_i.hs.valid & b_i.hs.ready;

  assign hs_evt = {w_hs, r_hs, aw_hs, ar_hs};

  // EXOKAY is response 2'b01
  assign excl_evt = {b_hs & (b_i.resp == resp_t'(2'b01)),
                     aw_hs & aw_i.lock,
                     ar_hs & ar_i.lock};

  assign stall_chan = {b_i.hs, w_i, r_i.hs, aw_i.hs, ar_i.hs};

  apm_event_counter #(
    .WIDTH (`APM_CW_CLK)
  ) i_cnt_clk (
    .clk_axi_i (clk_axi_i),
    .rst_n_i   (rst_n_i),
    .clr_i     (ctrl.clr),
    .inc_i     (ctrl.en),
    .stat_o    (stats[0])
  );

  for (genvar i = 0; i < 4; i++) begin : gen_hs
    apm_event_counter #(
      .WIDTH (`APM_CW_HS)
    ) i_cnt_hs (
      .clk_axi_i (clk_axi_i),
      .rst_n_i   (rst_n_i),
      .clr_i     (ctrl.clr),
      .inc_i     (ctrl.en & hs_evt[i]),
      .stat_o    (stats[1+i])
    );
  end

  // Reads open on AR and close on the last R beat
  apm_inflight_tracker i_fl_r (
    .clk_axi_i (clk_axi_i),
    .rst_n_i   (rst_n_i),
    .ctrl_i    (ctrl),
    .inc_i     (ar_hs),
    .dec_i     (r_hs & r_i.last),
    .acc_o     (stats[5]),
    .max_o     (stats[6])
  );

  apm_inflight_tracker i_fl_w (
    .clk_axi_i (clk_axi_i),
    .rst_n_i   (rst_n_i),
    .ctrl_i    (ctrl),
    .inc_i     (aw_hs),
    .dec_i     (b_hs),
    .acc_o     (stats[7]),
    .max_o     (stats[8])
  );

  // AR, AW, R, W, B
  for (genvar i = 0; i < 5; i++) begin : gen_stall
    apm_stall_tracker i_stall (
      .clk_axi_i (clk_axi_i),
      .rst_n_i   (rst_n_i),
      .ctrl_i    (ctrl),
      .chan_i    (stall_chan[i]),
      .total_o   (stats[9+2*i]),
      .max_o     (stats[10+2*i])
    );
  end

  for (genvar i = 0; i < 3; i++) begin : gen_excl
    apm_event_counter #(
      .WIDTH (`APM_CW_EXCL)
    ) i_cnt_excl (
      .clk_axi_i (clk_axi_i),
      .rst_n_i   (rst_n_i),
      .clr_i     (ctrl.clr),
      .inc_i     (ctrl.en & excl_evt[i]),
      .stat_o    (stats[19+i])
    );
  end

  apm_regs i_regs (
    .clk_axi_i (clk_axi_i),
    .rst_n_i   (rst_n_i),
    .psel_i    (psel_i),
    .penable_i (penable_i),
    .pwrite_i  (pwrite_i),
    .paddr_i   (paddr_i),
    .pwdata_i  (pwdata_i),
    .stats_i   (stats),
    .prdata_o  (prdata_o),
    .pslverr_o (pslverr_o),
    .ctrl_o    (ctrl)
  );

endmodule

`default_nettype wire

//--- tests/axi_perf_mon_chk.sv
////////////////////////////////////////
// AXI performance monitor checker
// APB phase and read in-flight sanity
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module axi_perf_mon_chk (
  input  wire logic               clk_axi_i,
  input  wire logic               rst_n_i,
  input  wire apm_pkg::cmd_chan_t ar_i,
  input  wire apm_pkg::r_chan_t   r_i,
  input  wire logic               psel_i,
  input  wire logic               penable_i
);

  import apm_pkg::*;

  logic        ar_hs;
  logic        r_last_hs;
  logic [15:0] rd_open_q;

  assign ar_hs     = ar_i.hs.valid & ar_i.hs.ready;
  assign r_last_hs = r_i.hs.valid & r_i.hs.ready & r_i.last;

  // Reads opened since reset, independent of the monitor enable
  always_ff @(posedge clk_axi_i) begin
    if (!rst_n_i) begin
      rd_open_q <= '0;
    end else if (ar_hs && !r_last_hs) begin
      rd_open_q <= rd_open_q + 1'b1;
    end else if (r_last_hs && !ar_hs) begin
      rd_open_q <= rd_open_q - 1'b1;
    end
  end

  a_penable_needs_psel : assert property (
    @(posedge clk_axi_i) disable iff (!rst_n_i) penable_i |-> psel_i
  ) else $error("penable_i high without psel_i");

  a_r_last_has_open_read : assert property (
    @(posedge clk_axi_i) disable iff (!rst_n_i)
      r_last_hs |-> ((rd_open_q != '0) || ar_hs)
  ) else $error("R last handshake with no read in flight");

endmodule

bind axi_perf_mon axi_perf_mon_chk i_axi_perf_mon_chk (
  .clk_axi_i (clk_axi_i),
  .rst_n_i   (rst_n_i),
  .ar_i      (ar_i),
  .r_i       (r_i),
  .psel_i    (psel_i),
  .penable_i (penable_i)
);

`default_nettype wire

//--- tests/tb_axi_perf_mon.sv
////////////////////////////////////////
// AXI performance monitor testbench
// Replays AXI cycles and APB accesses
// from a stimulus file and checks reads
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_axi_perf_mon;

  import apm_pkg::*;

  localparam int unsigned STIM_DEPTH     = 64;
  localparam int unsigned TIMEOUT_CYCLES = 5000;

  // Stimulus operation codes
  localparam logic [3:0] OP_END    = 4'h0;
  localparam logic [3:0] OP_AXI    = 4'h1;
  localparam logic [3:0] OP_WR     = 4'h2;
  localparam logic [3:0] OP_RD     = 4'h3;
  localparam logic [3:0] OP_RD_ERR = 4'h4;
  localparam logic [3:0] OP_WR_ERR = 4'h5;

  logic        clk_axi;
  logic        rst_n;
  cmd_chan_t   ar;
  cmd_chan_t   aw;
  r_chan_t     r;
  chan_hs_t    w;
  b_chan_t     b;
  logic        psel;
  logic        penable;
  logic        pwrite;
  apb_addr_t   paddr;
  apb_data_t   pwdata;
  apb_data_t   prdata;
  logic        pslverr;
  logic        stream_done = 1'b0;
  logic [63:0] stim_mem [0:STIM_DEPTH-1];

  axi_perf_mon i_axi_perf_mon (
    .clk_axi_i (clk_axi),
    .rst_n_i   (rst_n),
    .ar_i      (ar),
    .aw_i      (aw),
    .r_i       (r),
    .w_i       (w),
    .b_i       (b),
    .psel_i    (psel),
    .penable_i (penable),
    .pwrite_i  (pwrite),
    .paddr_i   (paddr),
    .pwdata_i  (pwdata),
    .prdata_o  (prdata),
    .pslverr_o (pslverr)
  );

  initial begin
    clk_axi = 1'b0;
    forever #10 clk_axi = ~clk_axi;
  end

  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "Run aborted");
  endtask

  task automatic check_word(input string name, input apb_data_t got, input apb_data_t exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s: got 0x%08h, expected 0x%08h", $time, name, got, exp);
      abort_run();
    end
  endtask

  task automatic check_slverr(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("MISMATCH time=%0t %s: got %b, expected %b", $time, name, got, exp);
      abort_run();
    end
  endtask

  // Channel nibbles from bit 16 down: AR, AW, R, W, B
  task automatic drive_axi(input apb_data_t chan_bits, input int unsigned cycles);
    repeat (cycles) begin
      @(posedge clk_axi);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      ar      <= cmd_chan_t'(chan_bits[18:16]);
      aw      <= cmd_chan_t'(chan_bits[14:12]);
      r       <= r_chan_t'(chan_bits[10:8]);
      w       <= chan_hs_t'(chan_bits[5:4]);
      b       <= b_chan_t'(chan_bits[3:0]);
    end
  endtask

  // Setup and access phase, sampled mid-cycle in the access phase
  task automatic apb_access(input logic write, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic slverr);
    @(posedge clk_axi);
    psel    <= 1'b1;
    penable <= 1'b0;
    pwrite  <= write;
    paddr   <= addr;
    pwdata  <= wdata;
    ar      <= '0;
    aw      <= '0;
    r       <= '0;
    w       <= '0;
    b       <= '0;
    @(posedge clk_axi);
    penable <= 1'b1;
    @(negedge clk_axi);
    rdata  = prdata;
    slverr = pslverr;
  endtask

  task automatic run_stream();
    logic [63:0] entry;
    logic [3:0]  op;
    int unsigned cycles;
    int unsigned idx;
    logic        at_end;
    apb_addr_t   addr;
    apb_data_t   data;
    apb_data_t   rdata;
    logic        slverr;
    string       name;
    idx    = 0;
    at_end = 1'b0;
    while (!at_end && idx < STIM_DEPTH) begin
      entry  = stim_mem[idx];
      op     = entry[63:60];
      cycles = {20'd0, entry[59:48]};
      addr   = entry[43:32];
      data   = entry[31:0];
      name   = $sformatf("prdata_o@0x%03h", addr);
      case (op)
        OP_END: at_end = 1'b1;
        OP_AXI: drive_axi(data, cycles);
        OP_WR: begin
          apb_access(1'b1, addr, data, rdata, slverr);
          check_slverr("pslverr_o", slverr, 1'b0);
        end
        OP_RD: begin
          apb_access(1'b0, addr, '0, rdata, slverr);
          check_slverr("pslverr_o", slverr, 1'b0);
          check_word(name, rdata, data);
        end
        OP_RD_ERR: begin
          apb_access(1'b0, addr, '0, rdata, slverr);
          check_slverr("pslverr_o", slverr, 1'b1);
          check_word(name, rdata, '0);
        end
        OP_WR_ERR: begin
          apb_access(1'b1, addr, data, rdata, slverr);
          check_slverr("pslverr_o", slverr, 1'b1);
        end
        default: begin
          $display("Unknown stimulus operation %0h in entry %0d", op, idx);
          abort_run();
        end
      endcase
      idx++;
    end
    @(posedge clk_axi);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  initial begin : stimulus
    rst_n   = 1'b0;
    ar      = '0;
    aw      = '0;
    r       = '0;
    w       = '0;
    b       = '0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    $readmemh("tests/axi_perf_mon_stim.txt", stim_mem);
    repeat (10) @(posedge clk_axi);
    rst_n <= 1'b1;
    run_stream();
    stream_done = 1'b1;
  end

  initial begin : watchdog
    int unsigned waited;
    waited = 0;
    while (!stream_done && waited < TIMEOUT_CYCLES) begin
      @(posedge clk_axi);
      waited++;
    end
    if (stream_done) begin
      $display("Verification passed");
      $finish;
    end else begin
      $display("Stimulus stream did not finish within %0d cycles", TIMEOUT_CYCLES);
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+hw
hw/apm_pkg.sv
hw/apm_event_counter.sv
hw/apm_stall_tracker.sv
hw/apm_inflight_tracker.sv
hw/apm_regs.sv
hw/axi_perf_mon.sv
tests/axi_perf_mon_chk.sv
tests/tb_axi_perf_mon.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_axi_perf_mon -f flist.f -o sim_tb

if ! ./obj_dir/sim_tb > sim.log 2>&1; then
  echo "Simulation exited with a non-zero status"
fi
cat sim.log

if grep -q "Verification passed" sim.log; then
  exit 0
fi
exit 1

//--- tests/axi_perf_mon_stim.txt
// Columns: op_count_addr_data in hex. op 0 end, 1 AXI cycles, 2 write, 3 read expect data,
// 4 read expect error, 5 write expect error. AXI data nibbles from bit 16: AR AW R W B
3_000_0000_000000A7
3_000_0004_00000000
1_004_0000_0007002D
3_000_0008_00000000
3_000_0010_00000000
3_000_0080_00000000
3_000_00B0_00000000
// Enabled handshakes, three locked
2_000_0004_00000001
1_003_0000_0007773D
1_002_0000_0006673C
3_000_0008_00000006
3_000_0010_00000005
3_000_0028_00000005
3_000_00A0_00000003
3_000_00B0_00000003
3_000_0008_00000010
// AR stall runs of 3, 5 and 20
2_000_0004_00000003
2_000_0004_00000001
1_003_0000_00040000
1_001_0000_00060000
1_005_0000_00040000
1_001_0000_00060000
3_000_0050_00000008
3_000_0058_00000005
1_014_0000_00040000
1_001_0000_00060000
3_000_0050_0000001C
3_000_0058_0000000F
3_000_005C_80000000
// Clear
2_000_0004_00000002
2_000_0004_00000000
3_000_0050_00000000
3_000_0058_00000000
3_000_005C_00000000
3_000_0008_00000000
3_000_0030_00000000
// Read in flight, sum 0+1+2+3+3+3+2+1
2_000_0004_00000001
1_003_0000_00060000
1_002_0000_00000000
1_003_0000_00000700
3_000_0030_0000000F
3_000_0038_00000003
// Bus errors
4_000_0200_00000000
5_000_0000_00000003
3_000_0004_00000001
4_000_00B8_00000000
0_000_0000_00000000
